//--- src/rv32i_params.svh
`ifndef RV32I_PARAMS_SVH
`define RV32I_PARAMS_SVH

// datapath and register file sizing
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// major opcodes, instr[6:0]
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111
`define OP_BRANCH   7'b1100011

// funct3 codes
`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

// funct7 bit that turns ADD into SUB
`define F7_SUB_BIT  5

`endif

//--- src/rv32i_pkg.sv
`include "rv32i_params.svh"

package rv32i_pkg;

    // data, address and instruction words
    typedef logic [`XLEN-1:0] rv32i_word;
    // register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // alu function, PASS_B is used by LUI
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // per-instruction control, built in decode
    typedef struct packed {
        alu_op_e alu_op;
        logic    src2_is_imm;
        logic    reg_write;
        logic    is_branch;
        // branch when operands differ
        logic    branch_on_ne;
    } ctrl_word_t;

    // fetch to decode
    typedef struct packed {
        logic      valid;
        rv32i_word pc;
        rv32i_word instr;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic       valid;
        ctrl_word_t ctrl;
        rv32i_word  pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        rv32i_word  rs1_data;
        rv32i_word  rs2_data;
        rv32i_word  imm;
    } id_ex_t;

    // execute to writeback, also the regfile write port
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        rv32i_word data;
    } ex_wb_t;

endpackage

//--- src/regfile.sv
`timescale 1ns/1ps
`include "rv32i_params.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rv32i_pkg::reg_addr_t rs1_addr_i,
    input  rv32i_pkg::reg_addr_t rs2_addr_i,
    output rv32i_pkg::rv32i_word rs1_data_o,
    output rv32i_pkg::rv32i_word rs2_data_o,
    input  rv32i_pkg::ex_wb_t    wr_i
);
    import rv32i_pkg::*;

    rv32i_word regs_q [`REG_COUNT];

    // valid write never targets x0, so regs_q[0] stays zero
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.valid) begin
            regs_q[wr_i.rd] <= wr_i.data;
        end
    end

    // x0 reads zero, same-cycle write is bypassed to the reader
    always_comb begin
        if (rs1_addr_i == '0)
            rs1_data_o = '0;
        else if (wr_i.valid && (wr_i.rd == rs1_addr_i))
            rs1_data_o = wr_i.data;
        else
            rs1_data_o = regs_q[rs1_addr_i];

        if (rs2_addr_i == '0)
            rs2_data_o = '0;
        else if (wr_i.valid && (wr_i.rd == rs2_addr_i))
            rs2_data_o = wr_i.data;
        else
            rs2_data_o = regs_q[rs2_addr_i];
    end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`include "rv32i_params.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    output rv32i_pkg::rv32i_word instr_addr_o,
    input  rv32i_pkg::rv32i_word instr_rdata_i,
    input  logic                 redirect_i,
    input  rv32i_pkg::rv32i_word redirect_pc_i,
    output rv32i_pkg::if_id_t    if_id_o
);
    import rv32i_pkg::*;

    rv32i_word pc_q;
    rv32i_word pc_next;
    if_id_t    if_id_q;

    // static not-taken, so only execute can change the flow
    always_comb begin
        if (redirect_i)
            pc_next = redirect_pc_i;
        else
            pc_next = pc_q + `XLEN'd4;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            pc_q <= `RESET_PC;
        else
            pc_q <= pc_next;
    end

    // instruction memory answers in the same cycle
    assign instr_addr_o = pc_q;

    // IF/ID register
    // word fetched during a redirect is on the wrong path
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_q <= '0;
        end else begin
            if_id_q.valid <= ~redirect_i;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= instr_rdata_i;
        end
    end

    assign if_id_o = if_id_q;

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps
`include "rv32i_params.svh"

module decode_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv32i_pkg::if_id_t if_id_i,
    input  logic              flush_i,
    input  rv32i_pkg::ex_wb_t wb_i,
    output rv32i_pkg::id_ex_t id_ex_o
);
    import rv32i_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_addr;
    rv32i_word  rs1_data;
    rv32i_word  rs2_data;
    rv32i_word  imm;
    ctrl_word_t ctrl;
    id_ex_t     id_ex_q;

    // fixed field positions
    assign opcode   = if_id_i.instr[6:0];
    assign rd_addr  = if_id_i.instr[11:7];
    assign funct3   = if_id_i.instr[14:12];
    assign rs1_addr = if_id_i.instr[19:15];
    assign rs2_addr = if_id_i.instr[24:20];
    assign funct7   = if_id_i.instr[31:25];

    // default is a harmless op: no write, no branch
    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            `OP_REG: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    `F3_ADD: ctrl.alu_op = funct7[`F7_SUB_BIT] ? ALU_SUB : ALU_ADD;
                    `F3_SLT: ctrl.alu_op = ALU_SLT;
                    `F3_XOR: ctrl.alu_op = ALU_XOR;
                    `F3_OR:  ctrl.alu_op = ALU_OR;
                    `F3_AND: ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            `OP_IMM: begin
                // only ADDI among the immediate ops
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_write   = (funct3 == `F3_ADD);
                imm = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
            end
            `OP_LUI: begin
                ctrl.alu_op      = ALU_PASS_B;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm = {if_id_i.instr[31:12], 12'b0};
            end
            `OP_BRANCH: begin
                // B-type offset, bit 0 always zero
                imm = {{20{if_id_i.instr[31]}}, if_id_i.instr[7],
                       if_id_i.instr[30:25], if_id_i.instr[11:8], 1'b0};
                ctrl.is_branch    = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                ctrl.branch_on_ne = (funct3 == `F3_BNE);
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // write port comes straight from EX/WB
    regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (wb_i)
    );

    // ID/EX register, flush kills the slot behind a taken branch
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q.valid    <= if_id_i.valid & ~flush_i;
            id_ex_q.ctrl     <= ctrl;
            id_ex_q.pc       <= if_id_i.pc;
            id_ex_q.rs1      <= rs1_addr;
            id_ex_q.rs2      <= rs2_addr;
            id_ex_q.rd       <= rd_addr;
            id_ex_q.rs1_data <= rs1_data;
            id_ex_q.rs2_data <= rs2_data;
            id_ex_q.imm      <= imm;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps
`include "rv32i_params.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rv32i_pkg::id_ex_t    id_ex_i,
    output rv32i_pkg::ex_wb_t    ex_wb_o,
    output logic                 redirect_o,
    output rv32i_pkg::rv32i_word redirect_pc_o
);
    import rv32i_pkg::*;

    logic      fwd_rs1;
    logic      fwd_rs2;
    logic      operands_eq;
    rv32i_word op_a;
    rv32i_word rs2_val;
    rv32i_word op_b;
    rv32i_word alu_res;
    ex_wb_t    ex_wb_q;

    // EX/WB valid already implies rd != x0
    assign fwd_rs1 = ex_wb_q.valid && (ex_wb_q.rd == id_ex_i.rs1);
    assign fwd_rs2 = ex_wb_q.valid && (ex_wb_q.rd == id_ex_i.rs2);

    assign op_a    = fwd_rs1 ? ex_wb_q.data : id_ex_i.rs1_data;
    assign rs2_val = fwd_rs2 ? ex_wb_q.data : id_ex_i.rs2_data;

    // immediate for ADDI and LUI
    assign op_b = id_ex_i.ctrl.src2_is_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            // signed compare
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // branch compares the forwarded register values, never the imm
    assign operands_eq = (op_a == rs2_val);

    always_comb begin
        redirect_o = 1'b0;
        if (id_ex_i.valid && id_ex_i.ctrl.is_branch) begin
            if (id_ex_i.ctrl.branch_on_ne)
                redirect_o = ~operands_eq;
            else
                redirect_o = operands_eq;
        end
    end

    // target is pc relative
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    // EX/WB register
    // x0 writes are dropped here and never retire
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_wb_q <= '0;
        end else begin
            ex_wb_q.valid <= id_ex_i.valid && id_ex_i.ctrl.reg_write && (id_ex_i.rd != '0);
            ex_wb_q.rd    <= id_ex_i.rd;
            ex_wb_q.data  <= alu_res;
        end
    end

    assign ex_wb_o = ex_wb_q;

endmodule

//--- src/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core (
    input  logic                 clk,
    input  logic                 rst_n_i,
    output rv32i_pkg::rv32i_word instr_addr_o,
    input  rv32i_pkg::rv32i_word instr_rdata_i,
    output logic                 wb_valid_o,
    output rv32i_pkg::reg_addr_t wb_rd_o,
    output rv32i_pkg::rv32i_word wb_data_o
);
    import rv32i_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    logic      redirect;
    rv32i_word redirect_pc;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_addr_o  (instr_addr_o),
        .instr_rdata_i (instr_rdata_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .if_id_o       (if_id)
    );

    // redirect doubles as the decode flush
    decode_stage u_decode (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .if_id_i (if_id),
        .flush_i (redirect),
        .wb_i    (ex_wb),
        .id_ex_o (id_ex)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_ex_i       (id_ex),
        .ex_wb_o       (ex_wb),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    // retire port mirrors the regfile write
    assign wb_valid_o = ex_wb.valid;
    assign wb_rd_o    = ex_wb.rd;
    assign wb_data_o  = ex_wb.data;

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);
    logic clk_q       = 1'b0;
    logic rst_n_q     = 1'b0;
    int   reset_count = 0;

    // free running, 50% duty
    always #(PERIOD_NS / 2) clk_q = ~clk_q;

    // reset released on a rising edge once RESET_CYCLES edges have passed
    always @(posedge clk_q) begin
        if (reset_count == RESET_CYCLES - 1)
            rst_n_q <= 1'b1;
        else
            reset_count <= reset_count + 1;
    end

    assign clk_o   = clk_q;
    assign rst_n_o = rst_n_q;

endmodule

//--- dv/rv32i_core_props.sv
`timescale 1ns/1ps

module rv32i_core_props (
    input logic                 clk,
    input logic                 rst_n_i,
    input rv32i_pkg::rv32i_word instr_addr_i,
    input logic                 wb_valid_i,
    input rv32i_pkg::reg_addr_t wb_rd_i,
    input logic                 redirect_i
);
    import rv32i_pkg::*;

    // x0 results are dropped in execute
    a_no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i |-> (wb_rd_i != '0))
        else $error("retire port shows a write to x0");

    // fetch address stays on word boundaries
    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_addr_i[1:0] == 2'b00)
        else $error("fetch address 0x%h is not word aligned", instr_addr_i);

    // sequential fetch unless execute redirects
    a_fetch_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        !redirect_i |=> (instr_addr_i == $past(instr_addr_i) + 32'd4))
        else $error("fetch address did not advance by 4 without a redirect");

endmodule

bind rv32i_core rv32i_core_props u_props (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .instr_addr_i (instr_addr_o),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o),
    .redirect_i   (redirect)
);

//--- dv/rv32i_core_tb.sv
`timescale 1ns/1ps
`include "rv32i_params.svh"

module rv32i_core_tb;
    import rv32i_pkg::*;

    localparam int NUM_TESTS    = 6;
    localparam int RESET_CYCLES = 10;
    // 256 bytes of program space, rom index is instr_addr[7:2]
    localparam int ROM_WORDS    = 64;
    // ADDI x0, x0, 0
    localparam rv32i_word  NOP_WORD = 32'h0000_0013;
    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_SUB   = 7'b0100000;

    // one program word and what it should retire
    typedef struct packed {
        rv32i_word  instr;
        logic [3:0] test_id;
        logic       retires;
        reg_addr_t  rd;
        rv32i_word  value;
    } row_t;

    logic      clk;
    logic      rst_n;
    rv32i_word instr_addr;
    rv32i_word instr_rdata;
    logic      wb_valid;
    reg_addr_t wb_rd;
    rv32i_word wb_data;

    row_t      prog_rows [$];
    int        retire_rows [$];
    rv32i_word rom [ROM_WORDS];
    int        last_row_of_test [NUM_TESTS+1];
    int        test_errs [NUM_TESTS+1];
    bit        test_done [NUM_TESTS+1];
    string     test_names [NUM_TESTS+1];
    row_t      cur_row;
    int        cur_test    = 1;
    int        next_retire = 0;
    int        cycle_count = 0;
    int        max_cycles  = 0;
    int        check_count = 0;
    int        error_count = 0;
    bit        first_fetch_checked = 1'b0;

    // RV32I instruction formats
    function automatic rv32i_word alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OP_REG};
    endfunction

    function automatic rv32i_word addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), `F3_ADD, 5'(rd), `OP_IMM};
    endfunction

    function automatic rv32i_word lui(input int rd, input int imm20);
        return {20'(imm20), 5'(rd), `OP_LUI};
    endfunction

    function automatic rv32i_word branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], `OP_BRANCH};
    endfunction

    task automatic add_row(input rv32i_word instr, input int test, input int retires,
                           input int rd, input rv32i_word value);
        row_t r;
        r.instr   = instr;
        r.test_id = 4'(test);
        r.retires = (retires != 0);
        r.rd      = 5'(rd);
        r.value   = value;
        prog_rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errs[cur_test]++;
            $display("CHECK FAILED at time %0t: %s expected 0x%h, got 0x%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input int t);
        test_done[t] = 1'b1;
        if (test_errs[t] == 0)
            $display("test %0d (%s): pass", t, test_names[t]);
        else
            $display("test %0d (%s): fail, %0d mismatches", t, test_names[t], test_errs[t]);
    endtask

    task automatic build_program();
        test_names[0] = "none";
        test_names[1] = "reset";
        test_names[2] = "immediates";
        test_names[3] = "register alu";
        test_names[4] = "forwarding";
        test_names[5] = "branches";
        test_names[6] = "x0 writes";
        // columns: instruction, test, retires, rd, expected value
        add_row(addi(1, 0, 5), 2, 1, 1, 32'h0000_0005);
        add_row(addi(2, 0, -3), 2, 1, 2, 32'hFFFF_FFFD);
        add_row(lui(3, 'h12345), 2, 1, 3, 32'h1234_5000);
        add_row(addi(4, 0, 2047), 2, 1, 4, 32'h0000_07FF);
        add_row(alu_rr(F7_BASE, `F3_ADD, 5, 1, 4), 3, 1, 5, 32'h0000_0804);
        add_row(alu_rr(F7_SUB, `F3_ADD, 6, 1, 4), 3, 1, 6, 32'hFFFF_F806);
        add_row(alu_rr(F7_BASE, `F3_AND, 7, 3, 2), 3, 1, 7, 32'h1234_5000);
        add_row(alu_rr(F7_BASE, `F3_OR, 8, 1, 4), 3, 1, 8, 32'h0000_07FF);
        add_row(alu_rr(F7_BASE, `F3_XOR, 9, 1, 4), 3, 1, 9, 32'h0000_07FA);
        // -3 < 5 signed, then 5 < -3
        add_row(alu_rr(F7_BASE, `F3_SLT, 10, 2, 1), 3, 1, 10, 32'h0000_0001);
        add_row(alu_rr(F7_BASE, `F3_SLT, 11, 1, 2), 3, 1, 11, 32'h0000_0000);
        // distance one from EX/WB, distance two through the regfile bypass
        add_row(addi(12, 0, 100), 4, 1, 12, 32'h0000_0064);
        add_row(alu_rr(F7_BASE, `F3_ADD, 13, 12, 12), 4, 1, 13, 32'h0000_00C8);
        add_row(alu_rr(F7_SUB, `F3_ADD, 14, 13, 12), 4, 1, 14, 32'h0000_0064);
        add_row(alu_rr(F7_BASE, `F3_ADD, 15, 14, 13), 4, 1, 15, 32'h0000_012C);
        add_row(addi(16, 0, 7), 4, 1, 16, 32'h0000_0007);
        add_row(addi(17, 0, 7), 4, 1, 17, 32'h0000_0007);
        // equal only when both fresh operands arrive, pc 68 to 80
        add_row(branch(`F3_BEQ, 16, 17, 12), 4, 0, 0, 32'h0);
        add_row(addi(18, 0, 1), 4, 0, 0, 32'h0);
        add_row(addi(19, 0, 2), 4, 0, 0, 32'h0);
        add_row(alu_rr(F7_BASE, `F3_ADD, 18, 16, 17), 4, 1, 18, 32'h0000_000E);
        // taken BEQ, pc 84 to 100, words at 88 and 92 squashed, 96 skipped
        add_row(branch(`F3_BEQ, 12, 14, 16), 5, 0, 0, 32'h0);
        add_row(addi(19, 0, 11), 5, 0, 0, 32'h0);
        add_row(addi(20, 0, 12), 5, 0, 0, 32'h0);
        add_row(addi(21, 0, 13), 5, 0, 0, 32'h0);
        add_row(addi(22, 0, -1), 5, 1, 22, 32'hFFFF_FFFF);
        // equal operands, falls through
        add_row(branch(`F3_BNE, 12, 14, 8), 5, 0, 0, 32'h0);
        add_row(addi(23, 0, 21), 5, 1, 23, 32'h0000_0015);
        add_row(addi(0, 0, 55), 6, 0, 0, 32'h0);
        add_row(alu_rr(F7_BASE, `F3_ADD, 0, 1, 4), 6, 0, 0, 32'h0);
        add_row(alu_rr(F7_BASE, `F3_ADD, 24, 0, 1), 6, 1, 24, 32'h0000_0005);
        add_row(alu_rr(F7_SUB, `F3_ADD, 25, 0, 1), 6, 1, 25, 32'hFFFF_FFFB);
        add_row(alu_rr(F7_BASE, `F3_OR, 26, 0, 0), 6, 1, 26, 32'h0000_0000);
        for (int t = 0; t <= NUM_TESTS; t++) begin
            last_row_of_test[t] = -1;
        end
        for (int i = 0; i < prog_rows.size(); i++) begin
            if (prog_rows[i].retires) begin
                retire_rows.push_back(i);
                last_row_of_test[int'(prog_rows[i].test_id)] = i;
            end
        end
    endtask

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    // combinational instruction memory, NOP outside the program space
    assign instr_rdata = (instr_addr[31:8] == '0) ? rom[instr_addr[7:2]] : NOP_WORD;

    rv32i_core DUT (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .instr_addr_o  (instr_addr),
        .instr_rdata_i (instr_rdata),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    // flop outputs sampled at the edge, held since the previous one
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (!rst_n) begin
            cur_test = 1;
            check_value("wb_valid_o", 32'(wb_valid), 32'd0);
        end else if (!first_fetch_checked) begin
            cur_test = 1;
            check_value("instr_addr_o", instr_addr, `RESET_PC);
            first_fetch_checked = 1'b1;
            report_test(1);
        end
        if (rst_n && wb_valid) begin
            if (next_retire >= retire_rows.size()) begin
                error_count++;
                $display("unexpected retire at time %0t: x%0d written with 0x%h %s",
                         $time, wb_rd, wb_data, "after the last expected result");
            end else begin
                cur_row  = prog_rows[retire_rows[next_retire]];
                cur_test = int'(cur_row.test_id);
                check_value("wb_rd_o", 32'(wb_rd), 32'(cur_row.rd));
                check_value("wb_data_o", wb_data, cur_row.value);
                if (retire_rows[next_retire] == last_row_of_test[cur_test])
                    report_test(cur_test);
                next_retire++;
            end
        end
    end

    initial begin
        build_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            if (i < prog_rows.size())
                rom[i] = prog_rows[i].instr;
            else
                rom[i] = NOP_WORD;
        end
        // program length, reset, pipeline drain, margin
        max_cycles = prog_rows.size() + RESET_CYCLES + 4 + 20;
        while (next_retire < retire_rows.size() && cycle_count < max_cycles)
            @(negedge clk);
        if (next_retire < retire_rows.size()) begin
            error_count++;
            $display("timeout: run stopped after %0d cycles with %0d results never retired",
                     cycle_count, retire_rows.size() - next_retire);
        end else begin
            // window for a stray retire after the last expected one
            repeat (4) @(negedge clk);
        end
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (!test_done[t])
                $display("test %0d (%s): did not finish", t, test_names[t]);
        end
        $display("summary: %0d checks, %0d errors, %0d of %0d results retired",
                 check_count, error_count, next_retire, retire_rows.size());
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/rv32i_pkg.sv
src/regfile.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv32i_core.sv
dv/tb_clock_gen.sv
dv/rv32i_core_props.sv
dv/rv32i_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv32i core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rv32i_core_tb -f flist.f -o sim_tb \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
